// ==== hw/trigRegs_params.svh ====
`ifndef TRIGREGS_PARAMS_SVH
`define TRIGREGS_PARAMS_SVH

// ####################
// channel counts and widths
// ####################
`define SYNC_CH     8
`define IND_CH      7
`define TIME_W      24
`define STRETCH_LEN 9
`define REG_IDX_W   8

// ####################
// register map, byte addresses
// ####################
`define ADDR_CTRL     'h000 // repeat count and driver mode.
`define ADDR_DELAY    'h004 // repeat delay and independent triggers.
`define ADDR_CFG      'h008
`define ADDR_DRV_CNT  'h048 // driver counter in upper half.
`define ADDR_DRV_PW   'h04C
`define ADDR_SYNC_PW  'h050 // channel n at +4*n.
`define ADDR_SYNC_DLY 'h070
`define ADDR_IND_PW   'h0B0
`define ADDR_IND_DLY  'h0CC
`define ADDR_BUSY     'h168
`define ADDR_WORK_CNT 'h200

`endif

// ==== hw/trigRegsPkg.sv ====
`include "trigRegs_params.svh"

package trigRegsPkg;

  // bus side.
  typedef logic [31:0] busAddrT;
  typedef logic [31:0] busDataT;
  typedef logic [3:0]  byteEnT;

  // word index, byte address over four.
  typedef logic [`REG_IDX_W-1:0] regIdxT;

  // register contents.
  typedef logic [`TIME_W-1:0] timeCntT;
  typedef logic [15:0]        repCntT;

  // one bit per channel.
  typedef logic [`SYNC_CH-1:0] syncLevT;
  typedef logic [`IND_CH-1:0]  indLevT;

endpackage

// ==== hw/regBusIf.sv ====
`timescale 1ns/1ps

interface regBusIf;

  trigRegsPkg::regIdxT  wrIdx;
  trigRegsPkg::byteEnT  wrBe;   // zero unless a writable word is hit.
  trigRegsPkg::busDataT wrData;
  trigRegsPkg::regIdxT  rdIdx;
  logic                 rdHit;  // address maps to a readable word.

  modport decoder (
    output wrIdx,
    output wrBe,
    output wrData,
    output rdIdx,
    output rdHit
  );

  modport bank (
    input wrIdx,
    input wrBe,
    input wrData,
    input rdIdx,
    input rdHit
  );

endinterface

// ==== hw/regDecoder.sv ====
`timescale 1ns/1ps
`include "trigRegs_params.svh"

module regDecoder
  import trigRegsPkg::*;
(
  input  logic    io_clk,
  input  logic    arstN,
  input  byteEnT  be,
  input  busAddrT addr,
  input  busDataT dataIn,
  regBusIf.decoder bus,
  output logic    drvStrobe,
  output indLevT  indStrobe
);

  localparam regIdxT idxCtrl    = regIdxT'(`ADDR_CTRL / 4);
  localparam regIdxT idxDelay   = regIdxT'(`ADDR_DELAY / 4);
  localparam regIdxT idxCfg     = regIdxT'(`ADDR_CFG / 4);
  localparam regIdxT idxDrvCnt  = regIdxT'(`ADDR_DRV_CNT / 4);
  localparam regIdxT idxDrvPw   = regIdxT'(`ADDR_DRV_PW / 4);
  localparam regIdxT idxBusy    = regIdxT'(`ADDR_BUSY / 4);
  localparam regIdxT idxWorkCnt = regIdxT'(`ADDR_WORK_CNT / 4);

  regIdxT idx;
  logic   inMap;
  logic   ctrlSel;
  logic   delaySel;
  logic   wrHit;
  logic   statusHit;

  // true when idx lies in a block of n channel words.
  function automatic logic inSpan(regIdxT i, int baseAddr, int n);
    return (int'(i) >= baseAddr / 4) && (int'(i) < baseAddr / 4 + n);
  endfunction

  assign idx   = addr[`REG_IDX_W+1:2]; // bits 1:0 dropped.
  assign inMap = (addr[31:`REG_IDX_W+2] == '0);

  assign ctrlSel  = inMap && (idx == idxCtrl);
  assign delaySel = inMap && (idx == idxDelay);

  assign wrHit = ctrlSel || delaySel
              || (inMap && (idx == idxCfg || idx == idxDrvPw))
              || (inMap && inSpan(idx, `ADDR_SYNC_PW, `SYNC_CH))
              || (inMap && inSpan(idx, `ADDR_SYNC_DLY, `SYNC_CH))
              || (inMap && inSpan(idx, `ADDR_IND_PW, `IND_CH))
              || (inMap && inSpan(idx, `ADDR_IND_DLY, `IND_CH));

  assign statusHit = inMap && (idx == idxDrvCnt || idx == idxBusy || idx == idxWorkCnt);

  assign bus.wrIdx  = idx;
  assign bus.wrBe   = wrHit ? be : '0;
  assign bus.wrData = dataIn;
  assign bus.rdIdx  = idx;
  assign bus.rdHit  = wrHit || statusHit;

  // ####################
  // trigger strobes
  // ####################
  always_ff @(posedge io_clk or negedge arstN) begin
    if (!arstN) begin
      drvStrobe <= 1'b0;
      indStrobe <= '0;
    end else begin
      drvStrobe <= ctrlSel & be[0] & dataIn[0];
      indStrobe <= (delaySel && be[0]) ? dataIn[`IND_CH-1:0] : '0; // one per lane.
    end
  end

endmodule

// ==== hw/ctrlRegs.sv ====
`timescale 1ns/1ps
`include "trigRegs_params.svh"

module ctrlRegs
  import trigRegsPkg::*;
(
  input  logic    io_clk,
  input  logic    arstN,
  regBusIf.bank   bus,
  output repCntT  logicRptNo,
  output logic    trigDefLev,
  output logic    trigMode,
  output logic    syncWorkingMode,
  output timeCntT logicRptDelay,
  output syncLevT syncTrigFirst,
  output syncLevT syncTrigDefLev,
  output syncLevT syncFbDefLev,
  output indLevT  indTrigDefLev,
  output logic    indTrigMode
);

  localparam regIdxT idxCtrl  = regIdxT'(`ADDR_CTRL / 4);
  localparam regIdxT idxDelay = regIdxT'(`ADDR_DELAY / 4);
  localparam regIdxT idxCfg   = regIdxT'(`ADDR_CFG / 4);

  logic    ctrlWr;
  logic    delayWr;
  logic    cfgWr;
  busDataT cfgWord;

  assign ctrlWr  = (bus.wrIdx == idxCtrl);
  assign delayWr = (bus.wrIdx == idxDelay);
  assign cfgWr   = (bus.wrIdx == idxCfg);

  always_ff @(posedge io_clk or negedge arstN) begin
    if (!arstN) begin
      logicRptNo      <= '0;
      trigDefLev      <= 1'b0;
      trigMode        <= 1'b0;
      syncWorkingMode <= 1'b0;
      logicRptDelay   <= '0;
      cfgWord         <= '0;
    end else begin
      // control word, bit 0 is the trigger and not stored.
      if (ctrlWr && bus.wrBe[1]) begin
        trigDefLev      <= bus.wrData[10];
        trigMode        <= bus.wrData[9];
        syncWorkingMode <= bus.wrData[8];
      end
      if (ctrlWr && bus.wrBe[2]) logicRptNo[7:0]  <= bus.wrData[23:16];
      if (ctrlWr && bus.wrBe[3]) logicRptNo[15:8] <= bus.wrData[31:24];
      // delay word lives in bytes 3:1.
      for (int b = 1; b < 4; b++) begin
        if (delayWr && bus.wrBe[b]) logicRptDelay[8*(b-1) +: 8] <= bus.wrData[8*b +: 8];
      end
      for (int b = 0; b < 4; b++) begin
        if (cfgWr && bus.wrBe[b]) cfgWord[8*b +: 8] <= bus.wrData[8*b +: 8];
      end
    end
  end

  assign syncTrigFirst  = cfgWord[7:0];
  assign syncTrigDefLev = cfgWord[15:8];
  assign syncFbDefLev   = cfgWord[23:16];
  assign indTrigDefLev  = cfgWord[30:24];
  assign indTrigMode    = cfgWord[31];

endmodule

// ==== hw/trigStretch.sv ====
`timescale 1ns/1ps
`include "trigRegs_params.svh"

module trigStretch #(
  parameter int LANES = 1
) (
  input  logic             io_clk,
  input  logic             arstN,
  input  logic [LANES-1:0] strobe,
  output logic [LANES-1:0] pulse
);

  localparam int cntW = $clog2(`STRETCH_LEN + 1);

  for (genvar l = 0; l < LANES; l++) begin : gLane
    logic [cntW-1:0] cnt;

    // a new strobe reloads the count mid pulse.
    always_ff @(posedge io_clk or negedge arstN) begin
      if (!arstN) begin
        cnt <= '0;
      end else if (strobe[l]) begin
        cnt <= cntW'(`STRETCH_LEN);
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
    end

    assign pulse[l] = (cnt != '0); // high for STRETCH_LEN cycles.
  end

endmodule

// ==== hw/channelTimingRegs.sv ====
`timescale 1ns/1ps
`include "trigRegs_params.svh"

module channelTimingRegs
  import trigRegsPkg::*;
(
  input  logic                     io_clk,
  input  logic                     arstN,
  regBusIf.bank                    bus,
  output timeCntT                  drvPulseWidth,
  output timeCntT [`SYNC_CH-1:0]   syncPulseWidth,
  output timeCntT [`SYNC_CH-1:0]   syncDelay,
  output timeCntT [`IND_CH-1:0]    indPulseWidth,
  output timeCntT [`IND_CH-1:0]    indDelay
);

  localparam int idxDrvPw   = `ADDR_DRV_PW / 4;
  localparam int idxSyncPw  = `ADDR_SYNC_PW / 4;
  localparam int idxSyncDly = `ADDR_SYNC_DLY / 4;
  localparam int idxIndPw   = `ADDR_IND_PW / 4;
  localparam int idxIndDly  = `ADDR_IND_DLY / 4;

  // byte 3 of the bus word has no storage.
  function automatic timeCntT mergeBytes(timeCntT cur, busDataT d, byteEnT be);
    timeCntT res;
    res = cur;
    for (int b = 0; b < `TIME_W / 8; b++) begin
      if (be[b]) res[8*b +: 8] = d[8*b +: 8];
    end
    return res;
  endfunction

  always_ff @(posedge io_clk or negedge arstN) begin
    if (!arstN) begin
      drvPulseWidth  <= '0;
      syncPulseWidth <= '0;
      syncDelay      <= '0;
      indPulseWidth  <= '0;
      indDelay       <= '0;
    end else begin
      if (bus.wrIdx == regIdxT'(idxDrvPw)) begin
        drvPulseWidth <= mergeBytes(drvPulseWidth, bus.wrData, bus.wrBe);
      end
      for (int ch = 0; ch < `SYNC_CH; ch++) begin
        if (bus.wrIdx == regIdxT'(idxSyncPw + ch))
          syncPulseWidth[ch] <= mergeBytes(syncPulseWidth[ch], bus.wrData, bus.wrBe);
        if (bus.wrIdx == regIdxT'(idxSyncDly + ch))
          syncDelay[ch] <= mergeBytes(syncDelay[ch], bus.wrData, bus.wrBe);
      end
      for (int ch = 0; ch < `IND_CH; ch++) begin
        if (bus.wrIdx == regIdxT'(idxIndPw + ch))
          indPulseWidth[ch] <= mergeBytes(indPulseWidth[ch], bus.wrData, bus.wrBe);
        if (bus.wrIdx == regIdxT'(idxIndDly + ch))
          indDelay[ch] <= mergeBytes(indDelay[ch], bus.wrData, bus.wrBe);
      end
    end
  end

endmodule

// ==== hw/readbackMux.sv ====
`timescale 1ns/1ps
`include "trigRegs_params.svh"

module readbackMux
  import trigRegsPkg::*;
(
  regBusIf.bank                  bus,
  input  repCntT                 logicRptNo,
  input  logic                   trigDefLev,
  input  logic                   trigMode,
  input  logic                   syncWorkingMode,
  input  timeCntT                logicRptDelay,
  input  syncLevT                syncTrigFirst,
  input  syncLevT                syncTrigDefLev,
  input  syncLevT                syncFbDefLev,
  input  indLevT                 indTrigDefLev,
  input  logic                   indTrigMode,
  input  timeCntT                drvPulseWidth,
  input  timeCntT [`SYNC_CH-1:0] syncPulseWidth,
  input  timeCntT [`SYNC_CH-1:0] syncDelay,
  input  timeCntT [`IND_CH-1:0]  indPulseWidth,
  input  timeCntT [`IND_CH-1:0]  indDelay,
  input  logic                   trigOut,
  input  indLevT                 indTrigOut,
  input  logic                   logicBusy,
  input  repCntT                 trigDriverCounter,
  input  busDataT                workFinishCnt,
  output busDataT                dataOut
);

  localparam regIdxT idxCtrl    = regIdxT'(`ADDR_CTRL / 4);
  localparam regIdxT idxDelay   = regIdxT'(`ADDR_DELAY / 4);
  localparam regIdxT idxCfg     = regIdxT'(`ADDR_CFG / 4);
  localparam regIdxT idxDrvCnt  = regIdxT'(`ADDR_DRV_CNT / 4);
  localparam regIdxT idxDrvPw   = regIdxT'(`ADDR_DRV_PW / 4);
  localparam regIdxT idxBusy    = regIdxT'(`ADDR_BUSY / 4);
  localparam regIdxT idxWorkCnt = regIdxT'(`ADDR_WORK_CNT / 4);

  busDataT rdWord;

  always_comb begin
    rdWord = '0;
    case (bus.rdIdx)
      idxCtrl:    rdWord = {logicRptNo, 5'd0, trigDefLev, trigMode, syncWorkingMode,
                            7'd0, trigOut};
      idxDelay:   rdWord = {logicRptDelay, 1'b0, indTrigOut};
      idxCfg:     rdWord = {indTrigMode, indTrigDefLev, syncFbDefLev, syncTrigDefLev,
                            syncTrigFirst};
      idxDrvCnt:  rdWord = {trigDriverCounter, 16'h0}; // lower half dropped.
      idxDrvPw:   rdWord = {8'h0, drvPulseWidth};
      idxBusy:    rdWord = {31'd0, logicBusy};
      idxWorkCnt: rdWord = workFinishCnt;
      default:    rdWord = '0;
    endcase
    // channel blocks.
    for (int ch = 0; ch < `SYNC_CH; ch++) begin
      if (bus.rdIdx == regIdxT'(`ADDR_SYNC_PW / 4 + ch))  rdWord = {8'h0, syncPulseWidth[ch]};
      if (bus.rdIdx == regIdxT'(`ADDR_SYNC_DLY / 4 + ch)) rdWord = {8'h0, syncDelay[ch]};
    end
    for (int ch = 0; ch < `IND_CH; ch++) begin
      if (bus.rdIdx == regIdxT'(`ADDR_IND_PW / 4 + ch))  rdWord = {8'h0, indPulseWidth[ch]};
      if (bus.rdIdx == regIdxT'(`ADDR_IND_DLY / 4 + ch)) rdWord = {8'h0, indDelay[ch]};
    end
  end

  assign dataOut = bus.rdHit ? rdWord : '0; // unmapped reads zero.

endmodule

// ==== hw/trigRegs.sv ====
`timescale 1ns/1ps
`include "trigRegs_params.svh"

module trigRegs
  import trigRegsPkg::*;
(
  input  logic                   io_clk,
  input  logic                   arstN,
  input  byteEnT                 be,
  input  busAddrT                addr,
  input  busDataT                dataIn,
  output busDataT                dataOut,
  input  logic                   logicBusy,
  input  repCntT                 trigDriverCounter,
  input  busDataT                workFinishCnt,
  output logic                   trigOut,
  output indLevT                 indTrigOut,
  output repCntT                 logicRptNo,
  output logic                   trigDefLev,
  output logic                   trigMode,
  output logic                   syncWorkingMode,
  output timeCntT                logicRptDelay,
  output syncLevT                syncTrigFirst,
  output syncLevT                syncTrigDefLev,
  output syncLevT                syncFbDefLev,
  output indLevT                 indTrigDefLev,
  output logic                   indTrigMode,
  output timeCntT                drvPulseWidth,
  output timeCntT [`SYNC_CH-1:0] syncPulseWidth,
  output timeCntT [`SYNC_CH-1:0] syncDelay,
  output timeCntT [`IND_CH-1:0]  indPulseWidth,
  output timeCntT [`IND_CH-1:0]  indDelay
);

  logic   drvStrobe;
  indLevT indStrobe;

  regBusIf bus ();

  // ####################
  // decode and storage
  // ####################
  regDecoder uDecoder (
    .io_clk(io_clk), .arstN(arstN), .be(be), .addr(addr), .dataIn(dataIn),
    .bus(bus), .drvStrobe(drvStrobe), .indStrobe(indStrobe)
  );

  ctrlRegs uCtrlRegs (
    .io_clk(io_clk), .arstN(arstN), .bus(bus),
    .logicRptNo(logicRptNo), .trigDefLev(trigDefLev), .trigMode(trigMode),
    .syncWorkingMode(syncWorkingMode), .logicRptDelay(logicRptDelay),
    .syncTrigFirst(syncTrigFirst), .syncTrigDefLev(syncTrigDefLev),
    .syncFbDefLev(syncFbDefLev), .indTrigDefLev(indTrigDefLev), .indTrigMode(indTrigMode)
  );

  channelTimingRegs uTimingRegs (
    .io_clk(io_clk), .arstN(arstN), .bus(bus),
    .drvPulseWidth(drvPulseWidth), .syncPulseWidth(syncPulseWidth), .syncDelay(syncDelay),
    .indPulseWidth(indPulseWidth), .indDelay(indDelay)
  );

  // ####################
  // trigger pulses
  // ####################
  trigStretch #(.LANES(1)) uDrvStretch (
    .io_clk(io_clk), .arstN(arstN), .strobe(drvStrobe), .pulse(trigOut)
  );

  trigStretch #(.LANES(`IND_CH)) uIndStretch (
    .io_clk(io_clk), .arstN(arstN), .strobe(indStrobe), .pulse(indTrigOut)
  );

  readbackMux uReadback (
    .bus(bus),
    .logicRptNo(logicRptNo), .trigDefLev(trigDefLev), .trigMode(trigMode),
    .syncWorkingMode(syncWorkingMode), .logicRptDelay(logicRptDelay),
    .syncTrigFirst(syncTrigFirst), .syncTrigDefLev(syncTrigDefLev),
    .syncFbDefLev(syncFbDefLev), .indTrigDefLev(indTrigDefLev), .indTrigMode(indTrigMode),
    .drvPulseWidth(drvPulseWidth), .syncPulseWidth(syncPulseWidth), .syncDelay(syncDelay),
    .indPulseWidth(indPulseWidth), .indDelay(indDelay),
    .trigOut(trigOut), .indTrigOut(indTrigOut), .logicBusy(logicBusy),
    .trigDriverCounter(trigDriverCounter), .workFinishCnt(workFinishCnt),
    .dataOut(dataOut)
  );

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
  output logic io_clk,
  output logic arstN
);

  initial begin
    io_clk = 1'b0;
    forever #20 io_clk = ~io_clk; // 40 ns period.
  end

  initial begin
    arstN = 1'b0;
    repeat (3) @(posedge io_clk);
    #2 arstN = 1'b1; // release just after the third edge.
  end

endmodule

// ==== test/trigRegsTb.sv ====
`timescale 1ns/1ps
`include "trigRegs_params.svh"

module trigRegsTb
  import trigRegsPkg::*;
();

  localparam int runCycles  = 1000; // reset, three read sweeps, writes and pulses.
  localparam int watchdogNs = runCycles * 40 * 3 / 2;

  logic                   io_clk;
  logic                   arstN;
  byteEnT                 be;
  busAddrT                addr;
  busDataT                dataIn;
  busDataT                dataOut;
  logic                   logicBusy;
  repCntT                 trigDriverCounter;
  busDataT                workFinishCnt;
  logic                   trigOut;
  indLevT                 indTrigOut;
  repCntT                 logicRptNo;
  logic                   trigDefLev;
  logic                   trigMode;
  logic                   syncWorkingMode;
  timeCntT                logicRptDelay;
  syncLevT                syncTrigFirst, syncTrigDefLev, syncFbDefLev;
  indLevT                 indTrigDefLev;
  logic                   indTrigMode;
  timeCntT                drvPulseWidth;
  timeCntT [`SYNC_CH-1:0] syncPulseWidth, syncDelay;
  timeCntT [`IND_CH-1:0]  indPulseWidth, indDelay;

  busDataT refWord [256];   // expected read value per word index.
  busDataT storeMask [256]; // stored bits, zero for words that hold nothing.
  int      errCnt;
  int      checkCnt;
  int      seed;
  string   testName;
  logic    onTiming;

  clockGen clkGen (.io_clk(io_clk), .arstN(arstN));

  trigRegs uut (.*);

  // ####################
  // reference model
  // ####################
  function automatic void buildMap();
    foreach (storeMask[i]) begin
      storeMask[i] = '0;
      refWord[i]   = '0;
    end
    storeMask[`ADDR_CTRL / 4]   = 32'hffff_0700; // count and mode bits.
    storeMask[`ADDR_DELAY / 4]  = 32'hffff_ff00;
    storeMask[`ADDR_CFG / 4]    = 32'hffff_ffff;
    storeMask[`ADDR_DRV_PW / 4] = 32'h00ff_ffff;
    for (int ch = 0; ch < `SYNC_CH; ch++) begin
      storeMask[`ADDR_SYNC_PW / 4 + ch]  = 32'h00ff_ffff;
      storeMask[`ADDR_SYNC_DLY / 4 + ch] = 32'h00ff_ffff;
    end
    for (int ch = 0; ch < `IND_CH; ch++) begin
      storeMask[`ADDR_IND_PW / 4 + ch]  = 32'h00ff_ffff;
      storeMask[`ADDR_IND_DLY / 4 + ch] = 32'h00ff_ffff;
    end
  endfunction

  function automatic void modelWrite(busAddrT a, busDataT d, byteEnT b);
    regIdxT i;
    i = a[`REG_IDX_W+1:2];
    if (a[31:`REG_IDX_W+2] != '0) return;
    for (int k = 0; k < 4; k++) begin
      if (b[k]) refWord[i][8*k +: 8] = d[8*k +: 8] & storeMask[i][8*k +: 8];
    end
  endfunction

  function automatic busDataT expRead(busAddrT a, logic drvP, indLevT indP);
    regIdxT  i;
    busDataT w;
    i = a[`REG_IDX_W+1:2];
    w = '0;
    if (a[31:`REG_IDX_W+2] == '0) begin
      w = refWord[i];
      case (int'(i) * 4)
        `ADDR_CTRL:     w[0] = drvP;
        `ADDR_DELAY:    w[6:0] = indP;
        `ADDR_DRV_CNT:  w = {trigDriverCounter, 16'h0};
        `ADDR_BUSY:     w = {31'd0, logicBusy};
        `ADDR_WORK_CNT: w = workFinishCnt;
        default: ;
      endcase
    end
    return w;
  endfunction

  assign onTiming = (addr[31:`REG_IDX_W+2] == '0)
                 && (storeMask[addr[`REG_IDX_W+1:2]] == 32'h00ff_ffff);

  // ####################
  // checks
  // ####################
  assert property (@(posedge io_clk) !arstN |-> (!trigOut && indTrigOut == '0 && dataOut == '0))
    else begin
      errCnt++;
      $display("** Error [reset] outputs under reset: expected 0, actual %b %h %h",
               $sampled(trigOut), $sampled(indTrigOut), $sampled(dataOut));
    end

  assert property (@(posedge io_clk) onTiming |-> dataOut[31:24] == 8'h00)
    else begin
      errCnt++;
      $display("** Error [%s] timing word upper byte: expected 00, actual %h",
               testName, $sampled(dataOut[31:24]));
    end

  task automatic checkEq(string what, busDataT exp, busDataT act);
    checkCnt++;
    assert (act === exp) else begin
      errCnt++;
      $display("** Error [%s] %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkPorts();
    checkEq("logicRptNo", refWord[0][31:16], logicRptNo);
    checkEq("trigDefLev", refWord[0][10], trigDefLev);
    checkEq("trigMode", refWord[0][9], trigMode);
    checkEq("syncWorkingMode", refWord[0][8], syncWorkingMode);
    checkEq("logicRptDelay", refWord[1][31:8], logicRptDelay);
    checkEq("config ports", refWord[`ADDR_CFG / 4],
            {indTrigMode, indTrigDefLev, syncFbDefLev, syncTrigDefLev, syncTrigFirst});
    checkEq("drvPulseWidth", refWord[`ADDR_DRV_PW / 4], drvPulseWidth);
    for (int ch = 0; ch < `SYNC_CH; ch++) begin
      checkEq($sformatf("syncPulseWidth[%0d]", ch), refWord[`ADDR_SYNC_PW / 4 + ch],
              syncPulseWidth[ch]);
      checkEq($sformatf("syncDelay[%0d]", ch), refWord[`ADDR_SYNC_DLY / 4 + ch], syncDelay[ch]);
    end
    for (int ch = 0; ch < `IND_CH; ch++) begin
      checkEq($sformatf("indPulseWidth[%0d]", ch), refWord[`ADDR_IND_PW / 4 + ch],
              indPulseWidth[ch]);
      checkEq($sformatf("indDelay[%0d]", ch), refWord[`ADDR_IND_DLY / 4 + ch], indDelay[ch]);
    end
    checkEq("trigOut", '0, trigOut);
    checkEq("indTrigOut", '0, indTrigOut);
  endtask

  // ####################
  // bus tasks
  // ####################
  task automatic busWrite(busAddrT a, busDataT d, byteEnT b);
    addr   = a;
    dataIn = d;
    be     = b;
    @(posedge io_clk); // sampled here.
    #2;
    be = '0;
    modelWrite(a, d, b);
  endtask

  task automatic readCheck(busAddrT a);
    addr = a;
    be   = '0;
    @(negedge io_clk);
    checkEq($sformatf("read %h", a), expRead(a, 1'b0, '0), dataOut);
    @(posedge io_clk);
    #2;
  endtask

  task automatic sweepReads();
    for (int i = 0; i < 256; i++) readCheck(busAddrT'(i * 4));
  endtask

  // one cycle of pulse checking at the address already on the bus.
  task automatic stepCheck(logic expDrv, indLevT expInd);
    @(negedge io_clk);
    checkEq("trigOut", expDrv, trigOut);
    checkEq("indTrigOut", expInd, indTrigOut);
    checkEq($sformatf("read %h", addr), expRead(addr, expDrv, expInd), dataOut);
    @(posedge io_clk);
    #2;
  endtask

  // ####################
  // tests
  // ####################
  task automatic writeReadback();
    busDataT d;
    testName = "writeReadback";
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 256; i++) begin
        if (storeMask[i] != '0) begin
          d = $random(seed);
          if (i == `ADDR_CTRL / 4) d[0] = 1'b0;    // keep the driver idle.
          if (i == `ADDR_DELAY / 4) d[6:0] = '0;
          busWrite(busAddrT'(i * 4), d, byteEnT'($random(seed)));
          readCheck(busAddrT'(i * 4));
        end
      end
    end
    sweepReads();
    checkPorts();
  endtask

  task automatic driverTrigger();
    testName = "driverTrigger";
    busWrite(`ADDR_CTRL, 32'h0000_0001, 4'b0001);
    stepCheck(1'b0, '0); // strobe is in the decoder.
    repeat (`STRETCH_LEN) stepCheck(1'b1, '0);
    stepCheck(1'b0, '0);
    busWrite(`ADDR_CTRL, 32'h0000_0001, 4'b0001);
    stepCheck(1'b0, '0);
    repeat (3) stepCheck(1'b1, '0);
    busWrite(`ADDR_CTRL, 32'h0000_0001, 4'b0001); // retrigger mid pulse.
    repeat (`STRETCH_LEN + 1) stepCheck(1'b1, '0);
    stepCheck(1'b0, '0);
  endtask

  task automatic indTriggers();
    indLevT mask;
    testName = "indTriggers";
    mask = indLevT'($random(seed));
    if (mask == '0 || mask == '1) mask = 7'h2d; // want both busy and idle lanes.
    busWrite(`ADDR_DELAY, {25'd0, mask}, 4'b0001);
    stepCheck(1'b0, '0);
    repeat (`STRETCH_LEN) stepCheck(1'b0, mask);
    stepCheck(1'b0, '0);
  endtask

  task automatic statusDecode();
    busAddrT dropped [12];
    testName          = "statusDecode";
    logicBusy         = 1'b1;
    trigDriverCounter = repCntT'($random(seed));
    workFinishCnt     = $random(seed);
    readCheck(`ADDR_DRV_CNT | 32'h3);
    readCheck(`ADDR_BUSY | 32'h1);
    readCheck(`ADDR_WORK_CNT | 32'h2);
    busWrite(`ADDR_DRV_PW | 32'h3, $random(seed), 4'b0111);
    readCheck(`ADDR_DRV_PW | 32'h1);
    readCheck((`ADDR_SYNC_DLY + 4) | 32'h2);
    dropped = '{'h00c, 'h040, 'h048, 'h090, 'h0ac, 'h0e8, 'h100, 'h168,
                'h200, 'h3fc, 'h400, 'h8000_0008};
    foreach (dropped[n]) busWrite(dropped[n], $random(seed), 4'hf);
    sweepReads();
    readCheck(32'h0000_0400); // aliases of kept words outside the map.
    readCheck(32'h8000_0008);
    checkPorts();
  endtask

  initial begin
    seed              = 32'hc087_e689;
    errCnt            = 0;
    checkCnt          = 0;
    be                = '0;
    addr              = '0;
    dataIn            = '0;
    logicBusy         = 1'b0;
    trigDriverCounter = '0;
    workFinishCnt     = '0;
    testName          = "reset";
    buildMap();
    @(posedge io_clk);
    @(negedge io_clk);
    checkPorts(); // still in reset.
    @(posedge arstN);
    @(posedge io_clk);
    #2;
    checkPorts();
    sweepReads();
    writeReadback();
    driverTrigger();
    indTriggers();
    statusDecode();
    $display("checks %0d, errors %0d", checkCnt, errCnt);
    if (errCnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #watchdogNs;
    $display("watchdog timeout, the tests did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hw
hw/trigRegsPkg.sv
hw/regBusIf.sv
hw/regDecoder.sv
hw/ctrlRegs.sv
hw/trigStretch.sv
hw/channelTimingRegs.sv
hw/readbackMux.sv
hw/trigRegs.sv
test/clockGen.sv
test/trigRegsTb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module trigRegsTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/VtrigRegsTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
exit 1
